/* cpu9_top.f */
design/cpu9_pkg.sv
design/cpu9_ctrl_if.sv
design/fetch_unit.sv
design/instruction_memory.sv
design/control_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/data_memory.sv
design/cpu9_top.sv
test/clock_gen.sv
test/cpu9_tb.sv

/* test/cpu9_tb.sv */
module cpu9_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu9_pkg::*;

    localparam int     CLK_PERIOD = 40;
    localparam int     N_RANDOM   = 4;             // Random straight-line programs
    localparam int     N_RUNS     = 5 + N_RANDOM;  // Directed runs plus random ones
    localparam longint TIMEOUT_NS = longint'(N_RUNS) * (CYCLE_LIMIT + 100) * CLK_PERIOD;

    logic               Clk;
    logic               rst_n;
    logic               start;
    logic               done;
    logic               imem_we;
    logic [PC_W-1:0]    imem_addr;
    instr_u             imem_data;
    logic [DMEM_AW-1:0] dbg_addr;
    logic [DATA_W-1:0]  dbg_data;

    logic [INSTR_W-1:0] prog [$];                  // Program of the current test
    logic [INSTR_W-1:0] imem_model [IMEM_DEPTH];   // Mirror of the instruction store
    logic [DATA_W-1:0]  model_mem [DMEM_DEPTH];    // Never cleared between tests
    integer             seed = 57938;

    clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) i_clock_gen (
        .Clk   (Clk),
        .rst_n (rst_n)
    );

    cpu9_top i_cpu9_top (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .start     (start),
        .done      (done),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    function automatic logic [INSTR_W-1:0] r_word(input logic [OP_W-1:0] op,
                                                  input int ra, input int rb);
        return {op, REG_AW'(ra), REG_AW'(rb), PAD_W'(0)};
    endfunction

    function automatic logic [INSTR_W-1:0] i_word(input logic [OP_W-1:0] op, input int imm);
        return {op, IMM_W'(imm)};                  // Negative imm wraps to 6 bits
    endfunction

    // ISA model, runs the mirrored program until DONE or the cycle limit
    function automatic void model_run();
        logic [DATA_W-1:0]  regs [4];
        logic [PC_W-1:0]    pc;
        logic [PC_W-1:0]    next_pc;
        logic [INSTR_W-1:0] ins;
        logic [OP_W-1:0]    op;
        logic [1:0]         ra;
        logic [1:0]         rb;
        logic [IMM_W-1:0]   imm;
        pc = '0;
        for (int r = 0; r < 4; r++) begin
            regs[r] = '0;                          // Cleared by the hold state
        end
        for (int cyc = 0; cyc < CYCLE_LIMIT; cyc++) begin
            ins = imem_model[pc];
            op  = ins[8:6];
            ra  = ins[5:4];
            rb  = ins[3:2];
            imm = ins[5:0];
            if (op == OP_DONE) begin
                break;
            end
            next_pc = pc + 1'b1;
            case (op)
                OP_ADD:   regs[1] = regs[ra] + regs[rb];
                OP_SUB:   regs[1] = regs[ra] - regs[rb];
                OP_AND:   regs[1] = regs[ra] & regs[rb];
                OP_LDI:   regs[1] = DATA_W'(imm);
                OP_LOAD:  regs[rb] = model_mem[regs[ra]];
                OP_BRZ: begin
                    if (regs[1] == '0) begin
                        next_pc = PC_W'(int'(pc) + int'($signed(imm)));
                    end
                end
                default:  model_mem[regs[ra]] = regs[rb];  // STORE
            endcase
            pc = next_pc;
        end
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %0d actual %0d", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Hold, load, run to done, then read back the whole data memory
    task automatic run_program(input string name);
        @(posedge Clk);
        start <= 1'b1;
        foreach (prog[i]) begin
            @(posedge Clk);
            imem_we   <= 1'b1;
            imem_addr <= PC_W'(i);
            imem_data <= prog[i];
            imem_model[i] = prog[i];
        end
        @(posedge Clk);
        imem_we <= 1'b0;
        @(negedge Clk);
        check_value({name, " done in hold"}, 8'd0, {7'd0, done}); // Must drop while held
        model_run();
        @(posedge Clk);
        start <= 1'b0;
        do begin
            @(negedge Clk);
        end while (!done);
        for (int a = 0; a < DMEM_DEPTH; a++) begin
            @(posedge Clk);
            dbg_addr <= DMEM_AW'(a);
            @(negedge Clk);                        // Debug read settled
            check_value($sformatf("%s mem[%0d]", name, a), model_mem[a], dbg_data);
        end
    endtask

    // LDI, ADD, SUB, AND with 8-bit wrap, leaves r1..r3 nonzero
    task automatic alu_program();
        prog = '{i_word(OP_LDI, 63), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 2),
                 i_word(OP_LDI, 50), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 3),
                 r_word(OP_ADD, 2, 3), r_word(OP_STORE, 3, 1), r_word(OP_ADD, 1, 1),
                 r_word(OP_ADD, 1, 2), r_word(OP_STORE, 2, 1), r_word(OP_SUB, 3, 2),
                 r_word(OP_STORE, 1, 1), r_word(OP_AND, 1, 2), r_word(OP_STORE, 1, 1),
                 i_word(OP_DONE, 0)};
    endtask

    // Stores of old registers land at 0 only if the restart cleared them
    task automatic restart_program();
        prog = '{r_word(OP_STORE, 2, 3), r_word(OP_STORE, 3, 1), r_word(OP_STORE, 1, 2),
                 i_word(OP_LDI, 45), r_word(OP_STORE, 1, 1), i_word(OP_DONE, 0)};
    endtask

    task automatic load_store_program();
        prog = '{i_word(OP_LDI, 7), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 2),
                 i_word(OP_LDI, 30), r_word(OP_STORE, 1, 2), r_word(OP_LOAD, 1, 3),
                 r_word(OP_ADD, 3, 3), r_word(OP_STORE, 2, 1), i_word(OP_DONE, 0)};
    endtask

    // Count 5 down to 0 in mem[0], exit branch at word 8, back branch at 11
    task automatic countdown_program();
        prog = '{i_word(OP_LDI, 1), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 2),
                 i_word(OP_LDI, 5), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 1),
                 r_word(OP_SUB, 1, 2), r_word(OP_STORE, 0, 1), i_word(OP_BRZ, 4),
                 r_word(OP_STORE, 1, 1), r_word(OP_SUB, 0, 0), i_word(OP_BRZ, -6),
                 i_word(OP_LDI, 33), r_word(OP_STORE, 1, 1), i_word(OP_DONE, 0)};
    endtask

    // Increments mem[40] forever and copies the count to mem[0] one cycle later
    // The last allowed cycle is the store to mem[40]
    task automatic endless_loop_program();
        prog = '{i_word(OP_LDI, 1), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 2),
                 i_word(OP_LDI, 40), r_word(OP_STORE, 0, 1), r_word(OP_LOAD, 0, 3),
                 r_word(OP_STORE, 3, 0), r_word(OP_LOAD, 3, 1), r_word(OP_ADD, 1, 2),
                 r_word(OP_STORE, 3, 1), r_word(OP_STORE, 0, 1), r_word(OP_SUB, 0, 0),
                 i_word(OP_BRZ, -5)};
    endtask

    task automatic random_program();
        logic [OP_W-1:0] ops [6];
        int              len;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_LDI, OP_LOAD, OP_STORE};
        len = 8 + ($unsigned($random(seed)) % 32);  // Fits in 64 words with DONE
        prog.delete();
        for (int i = 0; i < len; i++) begin
            // Low six bits cover fields, pad and imm alike
            prog.push_back(i_word(ops[$unsigned($random(seed)) % 6], $random(seed)));
        end
        prog.push_back(i_word(OP_DONE, 0));
    endtask

    initial begin
        start     = 1'b1;                          // Held until the first program is in
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        dbg_addr  = '0;
        for (int a = 0; a < DMEM_DEPTH; a++) begin
            model_mem[a] = '0;                     // Matches the reset contents
        end
        @(posedge rst_n);
        alu_program();
        run_program("alu");
        restart_program();
        run_program("restart");
        load_store_program();
        run_program("load_store");
        countdown_program();
        run_program("countdown");
        endless_loop_program();
        run_program("cycle_limit");
        for (int n = 0; n < N_RANDOM; n++) begin
            random_program();
            run_program($sformatf("random_%0d", n));
        end
        $display("PASS: all tests");
        $finish;
    end

    // Each run is bounded by the cycle limit plus load and margin
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: done never arrived within %0d ns", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* test/clock_gen.sv */
module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic Clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        Clk = 1'b0;
        forever #(PERIOD_NS / 2) Clk = ~Clk;  // Free-running
    end

    initial begin
        rst_n = 1'b0;                         // Active from time zero
        repeat (RESET_CYCLES) @(posedge Clk);
        rst_n <= 1'b1;
    end

endmodule

/* design/cpu9_top.sv */
module cpu9_top (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic                          start,
    output logic                          done,
    input  logic                          imem_we,
    input  logic [cpu9_pkg::PC_W-1:0]    imem_addr,
    input  cpu9_pkg::instr_u              imem_data,
    input  logic [cpu9_pkg::DMEM_AW-1:0] dbg_addr,
    output logic [cpu9_pkg::DATA_W-1:0]  dbg_data
);
    import cpu9_pkg::*;

    logic [PC_W-1:0]   pc;
    instr_u            instr;      // Current instruction
    logic              run;
    logic              clear;      // Hold state
    logic              zero;       // ALU result zero
    logic [DATA_W-1:0] data_a;
    logic [DATA_W-1:0] data_b;
    logic [DATA_W-1:0] data_r1;
    logic [DATA_W-1:0] wdata;      // Register write-back
    logic [DATA_W-1:0] mem_rdata;

    cpu9_ctrl_if ctrl_if ();

    fetch_unit i_fetch_unit (
        .Clk   (Clk),
        .rst_n (rst_n),
        .start (start),
        .ctrl  (ctrl_if.dp),
        .zero  (zero),
        .pc    (pc),
        .run   (run),
        .clear (clear),
        .done  (done)
    );

    instruction_memory i_instruction_memory (
        .Clk   (Clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_data),
        .pc    (pc),
        .instr (instr)
    );

    control_decoder i_control_decoder (
        .instr (instr),
        .run   (run),
        .ctrl  (ctrl_if.dec)
    );

    register_file i_register_file (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .ctrl    (ctrl_if.dp),
        .wdata   (wdata),
        .data_a  (data_a),
        .data_b  (data_b),
        .data_r1 (data_r1)
    );

    execute_unit i_execute_unit (
        .ctrl      (ctrl_if.dp),
        .data_a    (data_a),
        .data_b    (data_b),
        .data_r1   (data_r1),
        .mem_rdata (mem_rdata),
        .wdata     (wdata),
        .zero      (zero)
    );

    // Address is ra, store data is rb
    data_memory i_data_memory (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl_if.dp),
        .addr     (data_a),
        .wdata    (data_b),
        .rdata    (mem_rdata),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

/* design/data_memory.sv */
module data_memory (
    input  logic                          Clk,
    input  logic                          rst_n,
    cpu9_ctrl_if.dp                       ctrl,
    input  logic [cpu9_pkg::DATA_W-1:0]  addr,
    input  logic [cpu9_pkg::DATA_W-1:0]  wdata,
    output logic [cpu9_pkg::DATA_W-1:0]  rdata,
    input  logic [cpu9_pkg::DMEM_AW-1:0] dbg_addr,
    output logic [cpu9_pkg::DATA_W-1:0]  dbg_data
);
    import cpu9_pkg::*;

    logic [DATA_W-1:0] mem [DMEM_DEPTH];

    // Only reset clears the array, a restart keeps old results
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.mem_write) begin
            mem[addr] <= wdata;  // STORE
        end
    end

    assign rdata    = mem[addr];      // Processor port
    assign dbg_data = mem[dbg_addr];  // Debug port

endmodule

/* design/execute_unit.sv */
module execute_unit (
    cpu9_ctrl_if.dp                      ctrl,
    input  logic [cpu9_pkg::DATA_W-1:0] data_a,
    input  logic [cpu9_pkg::DATA_W-1:0] data_b,
    input  logic [cpu9_pkg::DATA_W-1:0] data_r1,
    input  logic [cpu9_pkg::DATA_W-1:0] mem_rdata,
    output logic [cpu9_pkg::DATA_W-1:0] wdata,
    output logic                         zero
);
    import cpu9_pkg::*;

    logic [DATA_W-1:0] imm_ext;  // Zero-extended immediate
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_out;

    assign imm_ext = DATA_W'(ctrl.imm);

    always_comb begin
        if (ctrl.branch) begin
            op_a = '0;               // Compare r1 against zero
            op_b = data_r1;
        end else if (ctrl.use_imm) begin
            op_a = '0;               // LDI
            op_b = imm_ext;
        end else begin
            op_a = data_a;
            op_b = data_b;
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            OP_SUB:  alu_out = op_a - op_b;  // Wraps at 8 bits
            OP_AND:  alu_out = op_a & op_b;
            default: alu_out = op_a + op_b;  // ADD, LDI
        endcase
    end

    assign zero  = (alu_out == '0);
    assign wdata = ctrl.mem_read ? mem_rdata : alu_out; // LOAD write-back

endmodule

/* design/register_file.sv */
module register_file (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         clear,
    cpu9_ctrl_if.dp                      ctrl,
    input  logic [cpu9_pkg::DATA_W-1:0] wdata,
    output logic [cpu9_pkg::DATA_W-1:0] data_a,
    output logic [cpu9_pkg::DATA_W-1:0] data_b,
    output logic [cpu9_pkg::DATA_W-1:0] data_r1
);
    import cpu9_pkg::*;

    logic [DATA_W-1:0] regs [1 << REG_AW];
    logic [REG_AW-1:0] waddr;

    assign waddr = ctrl.dest_from_rb ? ctrl.r_b : RESULT_REG; // LOAD targets rb

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (clear) begin        // Hold state wipes everything
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we) begin
            regs[waddr] <= wdata;
        end
    end

    assign data_a  = regs[ctrl.r_a];
    assign data_b  = regs[ctrl.r_b];
    assign data_r1 = regs[RESULT_REG];   // Branch test port

endmodule

/* design/control_decoder.sv */
module control_decoder (
    input  cpu9_pkg::instr_u instr,
    input  logic             run,
    cpu9_ctrl_if.dec         ctrl
);
    import cpu9_pkg::*;

    logic [OP_W-1:0] opcode;

    assign opcode = instr.r_fmt.opcode;  // Same bits in both views

    // Fields pass through, the enables decide whether they matter
    assign ctrl.r_a = instr.r_fmt.r_a;
    assign ctrl.r_b = instr.r_fmt.r_b;
    assign ctrl.imm = instr.i_fmt.imm;

    always_comb begin
        ctrl.alu_op       = OP_ADD;      // Default pass-through add
        ctrl.reg_we       = 1'b0;
        ctrl.dest_from_rb = 1'b0;
        ctrl.use_imm      = 1'b0;
        ctrl.mem_read     = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.branch       = 1'b0;
        ctrl.halt         = 1'b0;
        if (run) begin                   // Nothing fires outside run
            case (opcode)
                OP_ADD, OP_SUB, OP_AND: begin
                    ctrl.alu_op = opcode; // ALU codes match opcodes
                    ctrl.reg_we = 1'b1;
                end
                OP_DONE: begin
                    ctrl.halt = 1'b1;
                end
                OP_LDI: begin
                    ctrl.use_imm = 1'b1;  // 0 + imm
                    ctrl.reg_we  = 1'b1;
                end
                OP_LOAD: begin
                    ctrl.mem_read     = 1'b1;
                    ctrl.dest_from_rb = 1'b1;
                    ctrl.reg_we       = 1'b1;
                end
                OP_BRZ: begin
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = OP_SUB; // 0 - r1, zero iff r1 == 0
                end
                OP_STORE: begin
                    ctrl.mem_write = 1'b1;
                end
                default: begin
                    ctrl.halt = 1'b0;     // Unknown bits do nothing
                end
            endcase
        end
    end

endmodule

/* design/instruction_memory.sv */
module instruction_memory (
    input  logic                       Clk,
    input  logic                       we,
    input  logic [cpu9_pkg::PC_W-1:0] waddr,
    input  cpu9_pkg::instr_u           wdata,
    input  logic [cpu9_pkg::PC_W-1:0] pc,
    output cpu9_pkg::instr_u           instr
);
    import cpu9_pkg::*;

    instr_u mem [IMEM_DEPTH];  // Program store, loaded from outside

    // Load port
    always_ff @(posedge Clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign instr = mem[pc];    // Async fetch

endmodule

/* design/fetch_unit.sv */
module fetch_unit (
    input  logic                       Clk,
    input  logic                       rst_n,
    input  logic                       start,
    cpu9_ctrl_if.dp                    ctrl,
    input  logic                       zero,
    output logic [cpu9_pkg::PC_W-1:0] pc,
    output logic                       run,
    output logic                       clear,
    output logic                       done
);
    import cpu9_pkg::*;

    logic [1:0]         state;
    logic [1:0]         state_next;
    logic [CYCLE_W-1:0] cycle_cnt;  // Run cycles since start fell
    logic [CYCLE_W-1:0] cycle_inc;
    logic               limit_hit;
    logic [PC_W-1:0]    br_off;     // Signed branch offset
    logic [PC_W-1:0]    pc_next;

    assign cycle_inc = cycle_cnt + 1'b1;
    assign limit_hit = (cycle_inc == CYCLE_W'(CYCLE_LIMIT)); // Last allowed cycle

    assign br_off  = PC_W'(signed'(ctrl.imm)); // Sign-extend
    // Branch is low outside run, so decode alone picks the target
    assign pc_next = (ctrl.branch && zero) ? pc + br_off : pc + 1'b1;

    always_comb begin
        state_next = state;
        if (start) begin
            state_next = ST_HOLD;               // Start wins in every state
        end else begin
            case (state)
                ST_HOLD: state_next = ST_RUN;   // Start fell
                ST_RUN: begin
                    if (ctrl.halt || limit_hit) begin
                        state_next = ST_FIN;
                    end
                end
                ST_FIN:  state_next = ST_FIN;   // Wait for start
                default: state_next = ST_HOLD;
            endcase
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_HOLD;
            pc        <= '0;
            cycle_cnt <= '0;
        end else begin
            state <= state_next;
            if (start) begin
                pc        <= '0;                // Restart from word 0
                cycle_cnt <= '0;
            end else if (run) begin
                pc        <= pc_next;
                cycle_cnt <= cycle_inc;
            end
        end
    end

    assign run   = (state == ST_RUN);
    assign clear = (state == ST_HOLD);
    assign done  = (state == ST_FIN);

endmodule

/* design/cpu9_ctrl_if.sv */
interface cpu9_ctrl_if;
    import cpu9_pkg::*;

    logic [REG_AW-1:0] r_a;          // First register field
    logic [REG_AW-1:0] r_b;          // Second register field
    logic [IMM_W-1:0]  imm;          // Raw immediate
    logic [OP_W-1:0]   alu_op;       // ALU function
    logic              reg_we;       // Register write
    logic              dest_from_rb; // LOAD writes rb, not r1
    logic              use_imm;      // LDI operand select
    logic              mem_read;     // Write-back from memory
    logic              mem_write;    // STORE
    logic              branch;       // BRZ
    logic              halt;         // DONE

    modport dec (
        output r_a, r_b, imm, alu_op, reg_we, dest_from_rb,
        output use_imm, mem_read, mem_write, branch, halt
    );

    modport dp (
        input r_a, r_b, imm, alu_op, reg_we, dest_from_rb,
        input use_imm, mem_read, mem_write, branch, halt
    );

endinterface

/* design/cpu9_pkg.sv */
package cpu9_pkg;

    localparam int DATA_W      = 8;               // Data word width
    localparam int INSTR_W     = 9;               // Instruction width
    localparam int OP_W        = 3;               // Opcode field
    localparam int REG_AW      = 2;               // Four registers
    localparam int IMM_W       = 6;               // I-format immediate
    localparam int PAD_W       = INSTR_W - OP_W - 2 * REG_AW; // Unused R-format bits
    localparam int PC_W        = 6;               // Program counter
    localparam int IMEM_DEPTH  = 64;              // Program words
    localparam int DMEM_AW     = 8;               // Data memory address
    localparam int DMEM_DEPTH  = 1 << DMEM_AW;    // 256 bytes

    // Forced stop after this many run cycles
    localparam int CYCLE_LIMIT = 4096;
    localparam int CYCLE_W     = 13;              // Must hold CYCLE_LIMIT itself

    localparam logic [OP_W-1:0] OP_ADD   = 3'b000; // r1 = ra + rb
    localparam logic [OP_W-1:0] OP_SUB   = 3'b001; // r1 = ra - rb
    localparam logic [OP_W-1:0] OP_DONE  = 3'b010; // Halt
    localparam logic [OP_W-1:0] OP_AND   = 3'b011; // r1 = ra & rb
    localparam logic [OP_W-1:0] OP_LDI   = 3'b100; // r1 = zext(imm)
    localparam logic [OP_W-1:0] OP_LOAD  = 3'b101; // rb = mem[ra]
    localparam logic [OP_W-1:0] OP_BRZ   = 3'b110; // pc += sext(imm) if r1 == 0
    localparam logic [OP_W-1:0] OP_STORE = 3'b111; // mem[ra] = rb

    localparam logic [REG_AW-1:0] RESULT_REG = 2'd1; // Implicit ALU destination

    // Run controller states
    localparam logic [1:0] ST_HOLD = 2'd0;       // Held and cleared while start high
    localparam logic [1:0] ST_RUN  = 2'd1;       // One instruction per clock
    localparam logic [1:0] ST_FIN  = 2'd2;       // Done until start rises

    // Same 9 bits seen as R-format or I-format
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]   opcode;          // Bits 8..6
            logic [REG_AW-1:0] r_a;             // Bits 5..4
            logic [REG_AW-1:0] r_b;             // Bits 3..2
            logic [PAD_W-1:0]  pad;             // Bits 1..0, ignored
        } r_fmt;
        struct packed {
            logic [OP_W-1:0]  opcode;           // Bits 8..6
            logic [IMM_W-1:0] imm;              // Bits 5..0
        } i_fmt;
    } instr_u;

endpackage
